// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // Major opcodes of the RV32I subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB
  } aluop_t;

  // Instruction field positions
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  import cpu_pkg::*;

  typedef enum logic [2:0] {IF, ID, EX, MEM, WB} stage_e;

  localparam int NUM_STAGES = 5;

  // One bit per stage, set while that stage holds
  typedef logic [NUM_STAGES-1:0] stall_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    aluop_t    aluop;
    word_t     op_a;
    word_t     op_b;
    word_t     sdata;
    reg_addr_t rd;
    logic      wreg;
    logic      memrd;
    logic      memwr;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     result;
    word_t     sdata;
    reg_addr_t rd;
    logic      wreg;
    logic      memrd;
    logic      memwr;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    word_t     result;
    reg_addr_t rd;
    logic      wreg;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== regfile.sv ====
`default_nettype none

module regfile (
  input  wire logic               clk,
  input  wire logic               rst_i,
  input  wire pipe_pkg::mem_wb_t  mem_wb_i,
  input  wire cpu_pkg::reg_addr_t raddr1_i,
  input  wire cpu_pkg::reg_addr_t raddr2_i,
  output cpu_pkg::word_t          rdata1_o,
  output cpu_pkg::word_t          rdata2_o
);

  import cpu_pkg::*;

  word_t regs [0:31];
  logic  wr_en;

  assign wr_en = mem_wb_i.valid && mem_wb_i.wreg && (mem_wb_i.rd != '0);

  // x0 is never written
  always_ff @(posedge clk) begin
    if (!rst_i && wr_en) begin
      regs[mem_wb_i.rd] <= mem_wb_i.result;
    end
  end

  // Same-cycle write bypasses to the reads
  always_comb begin
    rdata1_o = regs[raddr1_i];
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else if (wr_en && mem_wb_i.rd == raddr1_i) begin
      rdata1_o = mem_wb_i.result;
    end
    rdata2_o = regs[raddr2_i];
    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else if (wr_en && mem_wb_i.rd == raddr2_i) begin
      rdata2_o = mem_wb_i.result;
    end
  end

endmodule

`default_nettype wire

// ==== ifetch.sv ====
`default_nettype none

module ifetch #(
  parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  wire logic             clk,
  input  wire logic             rst_i,
  input  wire pipe_pkg::stall_t stall_i,
  input  wire logic             redirect_i,
  input  wire cpu_pkg::word_t   target_i,
  input  wire cpu_pkg::word_t   inst_i,
  output logic                  inst_req_o,
  output cpu_pkg::word_t        inst_addr_o,
  output pipe_pkg::if_id_t      if_id_o
);

  import cpu_pkg::*;
  import pipe_pkg::*;

  word_t pc_q;
  logic  req_q;

  assign inst_req_o  = req_q;
  assign inst_addr_o = pc_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_q <= 1'b0;
      pc_q  <= RESET_PC;
    end else begin
      req_q <= 1'b1;
      // Redirect wins over a fetch stall
      if (redirect_i) begin
        pc_q <= target_i;
      end else if (req_q && !stall_i[IF]) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // IF/ID, squashed behind a redirect or a waiting fetch
  always_ff @(posedge clk) begin
    if (rst_i) begin
      if_id_o.valid <= 1'b0;
      if_id_o.instr <= NOP_INSTR;
    end else if (!stall_i[ID]) begin
      if (redirect_i || stall_i[IF] || !req_q) begin
        if_id_o.valid <= 1'b0;
        if_id_o.instr <= NOP_INSTR;
      end else begin
        if_id_o.valid <= 1'b1;
        if_id_o.pc    <= pc_q;
        if_id_o.instr <= inst_i;
      end
    end
  end

  a_target_aligned: assert property (@(posedge clk) disable iff (rst_i)
    redirect_i |-> target_i[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== id.sv ====
`default_nettype none

module id (
  input  wire logic               clk,
  input  wire logic               rst_i,
  input  wire pipe_pkg::stall_t   stall_i,
  input  wire pipe_pkg::if_id_t   if_id_i,
  output cpu_pkg::reg_addr_t      rs1_addr_o,
  output cpu_pkg::reg_addr_t      rs2_addr_o,
  input  wire cpu_pkg::word_t     rs1_data_i,
  input  wire cpu_pkg::word_t     rs2_data_i,
  input  wire pipe_pkg::mem_wb_t  ex_fwd_i,
  input  wire pipe_pkg::mem_wb_t  mem_fwd_i,
  input  wire logic               ex_memrd_i,
  output logic                    redirect_o,
  output cpu_pkg::word_t          target_o,
  output logic                    load_use_o,
  output pipe_pkg::id_ex_t        id_ex_o
);

  import cpu_pkg::*;
  import pipe_pkg::*;

  word_t      instr;
  opcode_t    opcode;
  reg_addr_t  rd;
  logic [2:0] funct3;
  logic       is_sub;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      rs1_val;
  word_t      rs2_val;
  logic       use_rs1;
  logic       use_rs2;
  logic       taken;
  id_ex_t     id_ex_d;

  // Newest value wins: EX, then MEM, then the register file
  function automatic word_t fwd_sel(reg_addr_t rs, word_t rf_val, mem_wb_t ex_f,
                                    mem_wb_t mem_f);
    if (ex_f.valid && ex_f.wreg && ex_f.rd == rs) begin
      return ex_f.result;
    end else if (mem_f.valid && mem_f.wreg && mem_f.rd == rs) begin
      return mem_f.result;
    end
    return rf_val;
  endfunction

  function automatic aluop_t alu_from_f3(logic [2:0] f3, logic sub);
    aluop_t op;
    case (f3)
      F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
      F3_SLT:  op = ALU_SLT;
      F3_XOR:  op = ALU_XOR;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign instr      = if_id_i.instr;
  assign opcode     = opcode_t'(instr[OPCODE_LSB +: OPCODE_W]);
  assign rd         = instr[RD_LSB +: 5];
  assign funct3     = instr[FUNCT3_LSB +: 3];
  assign is_sub     = instr[FUNCT7_LSB +: 7] == F7_SUB;
  assign rs1_addr_o = instr[RS1_LSB +: 5];
  assign rs2_addr_o = instr[RS2_LSB +: 5];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    rs1_val = fwd_sel(rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
    rs2_val = fwd_sel(rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);
  end

  assign use_rs1 = opcode inside {OP, OP_IMM, LOAD, STORE, BRANCH};
  assign use_rs2 = opcode inside {OP, STORE, BRANCH};

  // Load in EX feeding this instruction
  assign load_use_o = if_id_i.valid && ex_memrd_i && ex_fwd_i.wreg &&
                      ((use_rs1 && ex_fwd_i.rd == rs1_addr_o) ||
                       (use_rs2 && ex_fwd_i.rd == rs2_addr_o));

  always_comb begin
    taken    = 1'b0;
    target_o = if_id_i.pc + imm_b;
    case (opcode)
      BRANCH: begin
        if (funct3 == F3_BEQ) begin
          taken = rs1_val == rs2_val;
        end else if (funct3 == F3_BNE) begin
          taken = rs1_val != rs2_val;
        end
      end
      JAL: begin
        taken    = 1'b1;
        target_o = if_id_i.pc + imm_j;
      end
      default: ;
    endcase
  end

  // Only redirect once the branch leaves decode
  assign redirect_o = if_id_i.valid && taken && !stall_i[ID];

  always_comb begin
    id_ex_d.valid = if_id_i.valid;
    id_ex_d.aluop = ALU_ADD;
    id_ex_d.op_a  = rs1_val;
    id_ex_d.op_b  = imm_i;
    id_ex_d.sdata = rs2_val;
    id_ex_d.rd    = rd;
    id_ex_d.wreg  = 1'b0;
    id_ex_d.memrd = 1'b0;
    id_ex_d.memwr = 1'b0;
    case (opcode)
      OP: begin
        id_ex_d.aluop = alu_from_f3(funct3, is_sub);
        id_ex_d.op_b  = rs2_val;
        id_ex_d.wreg  = 1'b1;
      end
      OP_IMM: begin
        id_ex_d.aluop = alu_from_f3(funct3, 1'b0);
        id_ex_d.wreg  = 1'b1;
      end
      LUI: begin
        id_ex_d.aluop = ALU_PASSB;
        id_ex_d.op_b  = imm_u;
        id_ex_d.wreg  = 1'b1;
      end
      LOAD: begin
        id_ex_d.memrd = 1'b1;
        id_ex_d.wreg  = 1'b1;
      end
      STORE: begin
        id_ex_d.op_b  = imm_s;
        id_ex_d.memwr = 1'b1;
      end
      JAL: begin
        // Link value
        id_ex_d.aluop = ALU_PASSB;
        id_ex_d.op_b  = if_id_i.pc + 32'd4;
        id_ex_d.wreg  = 1'b1;
      end
      default: ;
    endcase
    if (rd == '0) begin
      id_ex_d.wreg = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o.valid <= 1'b0;
    end else if (!stall_i[EX]) begin
      if (stall_i[ID]) begin
        id_ex_o.valid <= 1'b0;
      end else begin
        id_ex_o <= id_ex_d;
      end
    end
  end

  a_no_redirect_on_load_use: assert property (@(posedge clk) disable iff (rst_i)
    redirect_o |-> !load_use_o);

endmodule

`default_nettype wire

// ==== ex.sv ====
`default_nettype none

module ex (
  input  wire logic             clk,
  input  wire logic             rst_i,
  input  wire pipe_pkg::stall_t stall_i,
  input  wire pipe_pkg::id_ex_t id_ex_i,
  output pipe_pkg::mem_wb_t     ex_fwd_o,
  output logic                  ex_memrd_o,
  output pipe_pkg::ex_mem_t     ex_mem_o
);

  import cpu_pkg::*;
  import pipe_pkg::*;

  word_t op_a;
  word_t op_b;
  word_t result;

  assign op_a = id_ex_i.op_a;
  assign op_b = id_ex_i.op_b;

  // Loads and stores use ALU_ADD for the address
  always_comb begin
    case (id_ex_i.aluop)
      ALU_ADD:   result = op_a + op_b;
      ALU_SUB:   result = op_a - op_b;
      ALU_AND:   result = op_a & op_b;
      ALU_OR:    result = op_a | op_b;
      ALU_XOR:   result = op_a ^ op_b;
      ALU_SLT:   result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_PASSB: result = op_b;
      default:   result = op_b;
    endcase
  end

  assign ex_fwd_o.valid  = id_ex_i.valid;
  assign ex_fwd_o.result = result;
  assign ex_fwd_o.rd     = id_ex_i.rd;
  assign ex_fwd_o.wreg   = id_ex_i.wreg;
  assign ex_memrd_o      = id_ex_i.valid && id_ex_i.memrd;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ex_mem_o.valid <= 1'b0;
    end else if (!stall_i[MEM]) begin
      if (stall_i[EX]) begin
        ex_mem_o.valid <= 1'b0;
      end else begin
        ex_mem_o.valid  <= id_ex_i.valid;
        ex_mem_o.result <= result;
        ex_mem_o.sdata  <= id_ex_i.sdata;
        ex_mem_o.rd     <= id_ex_i.rd;
        ex_mem_o.wreg   <= id_ex_i.wreg;
        ex_mem_o.memrd  <= id_ex_i.memrd;
        ex_mem_o.memwr  <= id_ex_i.memwr;
      end
    end
  end

endmodule

`default_nettype wire

// ==== mem.sv ====
`default_nettype none

module mem (
  input  wire logic              clk,
  input  wire logic              rst_i,
  input  wire pipe_pkg::stall_t  stall_i,
  input  wire pipe_pkg::ex_mem_t ex_mem_i,
  input  wire cpu_pkg::word_t    data_rdata_i,
  output logic                   data_req_o,
  output logic                   data_we_o,
  output cpu_pkg::word_t         data_addr_o,
  output cpu_pkg::word_t         data_wdata_o,
  output pipe_pkg::mem_wb_t      mem_fwd_o,
  output pipe_pkg::mem_wb_t      mem_wb_o
);

  import pipe_pkg::*;

  assign data_req_o   = ex_mem_i.valid && (ex_mem_i.memrd || ex_mem_i.memwr);
  assign data_we_o    = ex_mem_i.valid && ex_mem_i.memwr;
  assign data_addr_o  = ex_mem_i.result;
  assign data_wdata_o = ex_mem_i.sdata;

  // Load data is only good while the data port is not waiting
  assign mem_fwd_o.valid  = ex_mem_i.valid;
  assign mem_fwd_o.result = ex_mem_i.memrd ? data_rdata_i : ex_mem_i.result;
  assign mem_fwd_o.rd     = ex_mem_i.rd;
  assign mem_fwd_o.wreg   = ex_mem_i.wreg;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      mem_wb_o.valid <= 1'b0;
    end else if (!stall_i[WB]) begin
      if (stall_i[MEM]) begin
        mem_wb_o.valid <= 1'b0;
      end else begin
        mem_wb_o <= mem_fwd_o;
      end
    end
  end

  a_data_addr_aligned: assert property (@(posedge clk) disable iff (rst_i)
    data_req_o |-> data_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== ctrl.sv ====
`default_nettype none

module ctrl (
  input  wire logic      load_use_i,
  input  wire logic      inst_wait_i,
  input  wire logic      data_wait_i,
  output pipe_pkg::stall_t stall_o
);

  import pipe_pkg::*;

  // Writeback never holds
  always_comb begin
    stall_o = '0;
    if (inst_wait_i) begin
      stall_o[IF] = 1'b1;
    end
    if (load_use_i) begin
      stall_o[IF] = 1'b1;
      stall_o[ID] = 1'b1;
    end
    if (data_wait_i) begin
      stall_o[IF]  = 1'b1;
      stall_o[ID]  = 1'b1;
      stall_o[EX]  = 1'b1;
      stall_o[MEM] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== cpu.sv ====
`default_nettype none

module cpu #(
  parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  wire logic           clk,
  input  wire logic           rst_i,
  output logic                inst_req_o,
  output cpu_pkg::word_t      inst_addr_o,
  input  wire cpu_pkg::word_t inst_i,
  input  wire logic           inst_wait_i,
  output logic                data_req_o,
  output logic                data_we_o,
  output cpu_pkg::word_t      data_addr_o,
  output cpu_pkg::word_t      data_wdata_o,
  input  wire cpu_pkg::word_t data_rdata_i,
  input  wire logic           data_wait_i
);

  import cpu_pkg::*;
  import pipe_pkg::*;

  stall_t    stall;
  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  mem_wb_t   ex_fwd;
  mem_wb_t   mem_fwd;
  logic      ex_memrd;
  logic      redirect;
  word_t     target;
  logic      load_use;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  ctrl ctrl0 (
    .load_use_i (load_use),
    .inst_wait_i(inst_wait_i),
    .data_wait_i(data_wait_i),
    .stall_o    (stall)
  );

  regfile regfile0 (
    .clk     (clk),
    .rst_i   (rst_i),
    .mem_wb_i(mem_wb),
    .raddr1_i(rs1_addr),
    .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data),
    .rdata2_o(rs2_data)
  );

  ifetch #(
    .RESET_PC(RESET_PC)
  ) ifetch0 (
    .clk        (clk),
    .rst_i      (rst_i),
    .stall_i    (stall),
    .redirect_i (redirect),
    .target_i   (target),
    .inst_i     (inst_i),
    .inst_req_o (inst_req_o),
    .inst_addr_o(inst_addr_o),
    .if_id_o    (if_id)
  );

  id id0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall),
    .if_id_i   (if_id),
    .rs1_addr_o(rs1_addr),
    .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data),
    .ex_fwd_i  (ex_fwd),
    .mem_fwd_i (mem_fwd),
    .ex_memrd_i(ex_memrd),
    .redirect_o(redirect),
    .target_o  (target),
    .load_use_o(load_use),
    .id_ex_o   (id_ex)
  );

  ex ex0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall),
    .id_ex_i   (id_ex),
    .ex_fwd_o  (ex_fwd),
    .ex_memrd_o(ex_memrd),
    .ex_mem_o  (ex_mem)
  );

  mem mem0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .stall_i     (stall),
    .ex_mem_i    (ex_mem),
    .data_rdata_i(data_rdata_i),
    .data_req_o  (data_req_o),
    .data_we_o   (data_we_o),
    .data_addr_o (data_addr_o),
    .data_wdata_o(data_wdata_o),
    .mem_fwd_o   (mem_fwd),
    .mem_wb_o    (mem_wb)
  );

endmodule

`default_nettype wire

// ==== tb_mem.sv ====
`default_nettype none

module tb_mem #(
  parameter logic [31:0] BASE  = 32'h0000_0000,
  parameter int          DEPTH = 64,
  parameter logic [31:0] SEED  = 32'h57b0_f7af
) (
  input  wire logic        clk,
  input  wire logic        inst_req_i,
  input  wire logic [31:0] inst_addr_i,
  output logic [31:0]      inst_o,
  output logic             inst_wait_o,
  input  wire logic        data_req_i,
  input  wire logic        data_we_i,
  input  wire logic [31:0] data_addr_i,
  input  wire logic [31:0] data_wdata_i,
  output logic [31:0]      data_rdata_o,
  output logic             data_wait_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] rom [0:DEPTH-1];
  logic [31:0] ram [0:255];

  logic [31:0] inst_addr_q = 32'hffff_ffff;
  logic [31:0] inst_q      = 32'h0000_0013;
  logic [31:0] inst_next_q = 32'h0000_0013;
  logic        inst_busy   = 1'b0;
  logic        inst_hit;
  logic [31:0] data_addr_q = 32'hffff_ffff;
  logic [31:0] data_q      = 32'h0000_0000;
  logic        data_busy   = 1'b0;

  function automatic logic [31:0] rom_read(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BASE) >> 2;
    if (idx < DEPTH) begin
      return rom[idx];
    end
    return 32'h0000_0013;
  endfunction

  initial begin
    void'($urandom(SEED));
    // Fill depends on every address bit
    for (int i = 0; i < 256; i++) begin
      ram[i] = 32'hc3a5_0000 ^ (i * 32'h0101_0101) ^ (i << 2);
    end
  end

  // Data is registered from the address seen at the edge
  // Fetch also prepares the next sequential word
  // Any other address change shows up as a wait
  always @(posedge clk) begin
    inst_busy   <= ($urandom % 4) == 0;
    data_busy   <= ($urandom % 4) == 0;
    inst_addr_q <= inst_addr_i;
    inst_q      <= rom_read(inst_addr_i);
    inst_next_q <= rom_read(inst_addr_i + 32'd4);
    data_addr_q <= data_addr_i;
    if (data_req_i && data_we_i && !data_wait_o) begin
      ram[data_addr_i[9:2]] <= data_wdata_i;
      data_q                <= data_wdata_i;
    end else begin
      data_q <= ram[data_addr_i[9:2]];
    end
  end

  assign inst_hit     = (inst_addr_i == inst_addr_q) ||
                        (inst_addr_i == inst_addr_q + 32'd4);
  assign inst_o       = (inst_addr_i == inst_addr_q) ? inst_q : inst_next_q;
  assign inst_wait_o  = inst_req_i && (inst_busy || !inst_hit);
  assign data_rdata_o = data_q;
  assign data_wait_o  = data_req_i && (data_busy || data_addr_q != data_addr_i);

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

module tb_cpu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC  = 32'h0000_0100;
  localparam int          ROM_DEPTH = 64;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

  logic        clk   = 1'b0;
  logic        rst_i = 1'b1;
  logic        inst_req;
  logic [31:0] inst_addr;
  logic [31:0] inst_word;
  logic        inst_wait;
  logic        data_req;
  logic        data_we;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic        data_wait;

  logic [31:0] prog [$];
  string       prog_name [$];
  store_t      exp_store [$];
  string       exp_name [$];
  int          errors      = 0;
  int          store_count = 0;
  int          cycles      = 0;
  int          limit;
  logic        fetch_seen  = 1'b0;

  cpu #(
    .RESET_PC(RESET_PC)
  ) dut0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .inst_req_o  (inst_req),
    .inst_addr_o (inst_addr),
    .inst_i      (inst_word),
    .inst_wait_i (inst_wait),
    .data_req_o  (data_req),
    .data_we_o   (data_we),
    .data_addr_o (data_addr),
    .data_wdata_o(data_wdata),
    .data_rdata_i(data_rdata),
    .data_wait_i (data_wait)
  );

  tb_mem #(
    .BASE (RESET_PC),
    .DEPTH(ROM_DEPTH)
  ) mem0 (
    .clk         (clk),
    .inst_req_i  (inst_req),
    .inst_addr_i (inst_addr),
    .inst_o      (inst_word),
    .inst_wait_o (inst_wait),
    .data_req_i  (data_req),
    .data_we_i   (data_we),
    .data_addr_i (data_addr),
    .data_wdata_i(data_wdata),
    .data_rdata_o(data_rdata),
    .data_wait_o (data_wait)
  );

  always #20 clk = ~clk;

  // RV32I encoders
  function automatic logic [31:0] alu_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] alu_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                        logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_w(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] lw_w(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_w(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] br_w(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                       logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_w(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_instr(string name, logic [31:0] word);
    prog.push_back(word);
    prog_name.push_back(name);
  endtask

  task automatic add_store(string name, logic [31:0] addr, logic [31:0] data);
    exp_store.push_back({addr, data});
    exp_name.push_back(name);
  endtask

  task automatic build_tables();
    add_instr("alu", alu_i(3'b000, 1, 0, 12'h200));
    add_instr("alu", alu_i(3'b000, 2, 0, 12'd25));
    add_instr("alu", alu_i(3'b000, 3, 0, 12'hff9));
    add_instr("alu", alu_r(7'h00, 3'b000, 4, 2, 3));
    add_instr("alu", sw_w(4, 1, 12'd0));
    add_instr("alu", alu_r(7'h20, 3'b000, 5, 3, 2));
    add_instr("alu", sw_w(5, 1, 12'd4));
    add_instr("alu", alu_r(7'h00, 3'b111, 6, 2, 3));
    add_instr("alu", sw_w(6, 1, 12'd8));
    add_instr("alu", alu_r(7'h00, 3'b110, 7, 2, 3));
    add_instr("alu", sw_w(7, 1, 12'd12));
    add_instr("alu", alu_r(7'h00, 3'b100, 8, 2, 3));
    add_instr("alu", sw_w(8, 1, 12'd16));
    add_instr("alu", alu_r(7'h00, 3'b010, 9, 3, 2));
    add_instr("alu", alu_r(7'h00, 3'b010, 10, 2, 3));
    add_instr("alu", sw_w(9, 1, 12'd20));
    add_instr("alu", sw_w(10, 1, 12'd24));
    add_instr("imm", lui_w(11, 20'h12345));
    add_instr("imm", alu_i(3'b110, 11, 11, 12'h678));
    add_instr("imm", sw_w(11, 1, 12'd28));
    add_instr("imm", alu_i(3'b111, 12, 11, 12'h0f0));
    add_instr("imm", alu_i(3'b100, 13, 12, 12'hfff));
    add_instr("imm", sw_w(13, 1, 12'd32));
    add_instr("imm", sw_w(12, 1, 12'd36));
    add_instr("fwd", alu_i(3'b000, 14, 0, 12'd1));
    add_instr("fwd", alu_i(3'b000, 14, 14, 12'd2));
    add_instr("fwd", alu_i(3'b000, 14, 14, 12'd4));
    add_instr("fwd", alu_r(7'h00, 3'b000, 15, 14, 14));
    add_instr("fwd", sw_w(15, 1, 12'd40));
    add_instr("load", lw_w(16, 1, 12'd28));
    add_instr("load", alu_i(3'b000, 17, 16, 12'd1));
    add_instr("load", sw_w(17, 1, 12'd44));
    add_instr("load", lw_w(18, 1, 12'd0));
    add_instr("load", sw_w(18, 1, 12'd48));
    add_instr("branch", br_w(3'b000, 2, 3, 13'd8));
    add_instr("branch", alu_i(3'b000, 19, 0, 12'd5));
    add_instr("branch", br_w(3'b001, 2, 3, 13'd8));
    add_instr("branch", sw_w(0, 1, 12'd52));
    add_instr("branch", sw_w(19, 1, 12'd52));
    add_instr("branch", alu_i(3'b000, 20, 2, 12'd0));
    add_instr("branch", br_w(3'b000, 20, 2, 13'd8));
    add_instr("branch", sw_w(19, 1, 12'd56));
    add_instr("branch", br_w(3'b001, 20, 2, 13'd8));
    add_instr("jal", jal_w(21, 21'd8));
    add_instr("jal", sw_w(0, 1, 12'd56));
    add_instr("jal", sw_w(21, 1, 12'd56));
    add_instr("jal", lw_w(22, 1, 12'd56));
    add_instr("jal", br_w(3'b001, 22, 21, 13'd8));
    add_instr("jal", sw_w(22, 1, 12'd60));
    // Park in a self loop
    add_instr("end", jal_w(0, 21'd0));

    add_store("add", 32'h200, 32'd18);
    add_store("sub", 32'h204, 32'hffff_ffe0);
    add_store("and", 32'h208, 32'h0000_0019);
    add_store("or", 32'h20c, 32'hffff_fff9);
    add_store("xor", 32'h210, 32'hffff_ffe0);
    add_store("slt_true", 32'h214, 32'd1);
    add_store("slt_false", 32'h218, 32'd0);
    add_store("lui_ori", 32'h21c, 32'h1234_5678);
    add_store("xori", 32'h220, 32'hffff_ff8f);
    add_store("andi", 32'h224, 32'h0000_0070);
    add_store("fwd_chain", 32'h228, 32'd14);
    add_store("load_use", 32'h22c, 32'h1234_5679);
    add_store("load_store", 32'h230, 32'd18);
    add_store("bne_taken", 32'h234, 32'd5);
    add_store("jal_link", 32'h238, RESET_PC + 32'd176);
    add_store("load_branch", 32'h23c, RESET_PC + 32'd176);
  endtask

  task automatic check_store();
    if (store_count >= exp_store.size()) begin
      $display("Unexpected store beyond the table to 0x%08h with 0x%08h",
               data_addr, data_wdata);
      errors++;
    end else begin
      if (data_addr != exp_store[store_count].addr ||
          data_wdata != exp_store[store_count].data) begin
        $display("[ERROR] %s: expected addr 0x%08h data 0x%08h, got addr 0x%08h data 0x%08h",
                 exp_name[store_count], exp_store[store_count].addr,
                 exp_store[store_count].data, data_addr, data_wdata);
        errors++;
      end
    end
    store_count++;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (rst_i) begin
      if (inst_req || data_req) begin
        $display("A memory request was raised while reset was high");
        errors++;
      end
    end else begin
      if (inst_req && !fetch_seen) begin
        fetch_seen = 1'b1;
        if (inst_addr != RESET_PC) begin
          $display("[ERROR] reset_pc: expected 0x%08h, got 0x%08h", RESET_PC, inst_addr);
          errors++;
        end
      end
      if (data_req && data_we && !data_wait) begin
        check_store();
      end
    end
  end

  initial begin
    build_tables();
    for (int i = 0; i < ROM_DEPTH; i++) begin
      if (i < prog.size()) begin
        mem0.rom[i] = prog[i];
        if (i == 0 || prog_name[i] != prog_name[i-1]) begin
          $display("Section %s starts at word %0d", prog_name[i], i);
        end
      end else begin
        mem0.rom[i] = 32'h0000_0013;
      end
    end
    limit = 20 * prog.size() + 100;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
    while (store_count < exp_store.size() && cycles < limit) begin
      @(posedge clk);
    end
    if (store_count < exp_store.size()) begin
      $display("Timeout: the program did not finish within %0d cycles", limit);
      errors++;
    end else begin
      // Catch stores that should never happen
      repeat (20) @(posedge clk);
    end
    $display("Stores checked %0d of %0d, errors %0d", store_count, exp_store.size(), errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu.f ====
cpu_pkg.sv
pipe_pkg.sv
regfile.sv
ifetch.sv
id.sv
ex.sv
mem.sv
ctrl.sv
cpu.sv
tb_mem.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status follows the testbench verdict
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f cpu.f -o tb_cpu_sim \
  && ./obj_dir/tb_cpu_sim | tee /dev/stderr | grep -q "^Regression passed$" \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
